// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing -j 0
TOP     := tb_lsu_top
FLIST   := files.f
OBJ_DIR := obj_dir
LOG     := sim.log

SRCS    := $(wildcard hw/*.sv hw/*.svh tb/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+hw
hw/lsu_mem_pkg.sv
hw/lsu_core_pkg.sv
hw/lsu_disp_if.sv
hw/bit_pick_1_index.sv
hw/lsu_scheduler.sv
hw/lsu_pipe.sv
hw/lsu_phy_regfile.sv
hw/lsu_top.sv
tb/tb_lsu_top.sv

// ==== hw/bit_pick_1_index.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module bit_pick_1_index #(
   parameter int NUM = 0
) (
   input  logic [`LSU_DISP_SIZE-1:0] i_valids,
   input  lsu_core_pkg::disp_t       i_data[`LSU_DISP_SIZE],
   output logic                      o_valid,
   output lsu_core_pkg::disp_t       o_data,
   output logic [`LSU_DISP_SIZE-1:0] o_picked_pos
);

   always_comb begin
      int cnt;
      cnt          = 0;
      o_valid      = 1'b0;
      o_data       = '0;
      o_picked_pos = '0;
      for (int i = 0; i < `LSU_DISP_SIZE; i++) begin
         if (i_valids[i]) begin
            if (cnt == NUM) begin  // Rank NUM among set bits.
               o_valid         = 1'b1;
               o_data          = i_data[i];
               o_picked_pos[i] = 1'b1;
            end
            cnt = cnt + 1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/lsu_core_pkg.sv ====
`default_nettype none

`include "lsu_defines.svh"

package lsu_core_pkg;

   import lsu_mem_pkg::*;

   // One load slot as it leaves rename.
   typedef struct packed {
      mem_op_t                 opcode;
      logic [`LSU_PREG_W-1:0]  rd;
      logic [`LSU_PREG_W-1:0]  rs1;
      logic                    rs1_ready;
      logic signed [11:0]      imm;
   } disp_t;

   // Scheduler payload handed to the load pipe.
   typedef struct packed {
      disp_t                     inst;
      logic [`LSU_CMT_ID_W-1:0]  cmt_id;
      logic [`LSU_DISP_SIZE-1:0] grp_id;   // One-hot slot within the group.
   } issue_t;

   // Early write used for wakeup only.
   typedef struct packed {
      logic                    valid;
      logic [`LSU_PREG_W-1:0]  rd;
   } early_wr_t;

   // Register file write.
   typedef struct packed {
      logic                    valid;
      logic [`LSU_PREG_W-1:0]  rd;
      logic [`LSU_XLEN-1:0]    data;
   } phy_wr_t;

endpackage

`default_nettype wire

// ==== hw/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Dispatch group and scheduler sizing.
`define LSU_DISP_SIZE       4
`define LSU_SCHED_ENTRIES   8

// Physical register file.
`define LSU_PHY_REGS        32
`define LSU_PREG_W          5     // Register index width.
`define LSU_XLEN            32

// Data scratchpad standing in for the L1D.
`define LSU_MEM_WORDS       64
`define LSU_ADDR_W          8     // Byte address width.

// Commit group tag carried through the pipe.
`define LSU_CMT_ID_W        4

`endif

// ==== hw/lsu_disp_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

interface lsu_disp_if;

   import lsu_core_pkg::*;

   logic                      valid;        // Single-cycle strobe.
   logic [`LSU_CMT_ID_W-1:0]  cmt_id;
   logic [`LSU_DISP_SIZE-1:0] slot_valid;
   disp_t                     inst[`LSU_DISP_SIZE];

   // Scheduler side only needs the group tag.
   modport slave (
      input valid,
      input cmt_id
   );

   // Observes the whole group.
   modport monitor (
      input valid,
      input cmt_id,
      input slot_valid,
      input inst
   );

endinterface

`default_nettype wire

// ==== hw/lsu_mem_pkg.sv ====
`default_nettype none

package lsu_mem_pkg;

   // Load opcodes.
   typedef enum logic [2:0] {
      OP_LB  = 3'd0,
      OP_LH  = 3'd1,
      OP_LW  = 3'd2,
      OP_LBU = 3'd3,
      OP_LHU = 3'd4
   } mem_op_t;

   // Reservation station entry state.
   typedef enum logic [1:0] {
      ENTRY_EMPTY = 2'd0,
      ENTRY_WAIT  = 2'd1,   // Waiting on rs1.
      ENTRY_READY = 2'd2
   } sched_state_t;

endpackage

`default_nettype wire

// ==== hw/lsu_phy_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_phy_regfile (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  lsu_core_pkg::phy_wr_t  i_wr[2],
   input  logic [`LSU_PREG_W-1:0] i_rd_idx,
   output logic [`LSU_XLEN-1:0]   o_rd_data
);

   logic [`LSU_XLEN-1:0] r_regs[`LSU_PHY_REGS];

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `LSU_PHY_REGS; i++) begin
            r_regs[i] <= '0;
         end
      end else begin
         for (int w = 0; w < 2; w++) begin   // Port 1 applied last.
            if (i_wr[w].valid) begin
               r_regs[i_wr[w].rd] <= i_wr[w].data;
            end
         end
      end
   end

   // Write-through read with priority to the pipe writeback.
   always_comb begin
      o_rd_data = r_regs[i_rd_idx];
      for (int w = 0; w < 2; w++) begin
         if (i_wr[w].valid && i_wr[w].rd == i_rd_idx) begin
            o_rd_data = i_wr[w].data;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/lsu_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_pipe (
   input  logic                      i_clk,
   input  logic                      i_arst_n,

   input  logic                      i_rv0_valid,
   input  lsu_core_pkg::issue_t      i_rv0_issue,

   output logic [`LSU_PREG_W-1:0]    o_ex1_rs1,
   input  logic [`LSU_XLEN-1:0]      i_ex1_rs1_data,
   output lsu_core_pkg::early_wr_t   o_ex1_early_wr,

   input  logic                      i_mem_wr_valid,
   input  logic [`LSU_ADDR_W-1:0]    i_mem_wr_addr,
   input  logic [`LSU_XLEN-1:0]      i_mem_wr_data,

   output lsu_core_pkg::phy_wr_t     o_ex3_phy_wr,
   output logic [`LSU_CMT_ID_W-1:0]  o_ex3_cmt_id,
   output logic [`LSU_DISP_SIZE-1:0] o_ex3_grp_id
);

   import lsu_core_pkg::*;
   import lsu_mem_pkg::*;

   logic [`LSU_XLEN-1:0] r_mem[`LSU_MEM_WORDS];

   logic                 r_ex1_valid;
   issue_t               r_ex1_issue;
   logic [`LSU_XLEN-1:0] w_ex1_addr;
   logic [`LSU_XLEN-1:0] w_ex1_word;

   logic                      r_ex2_valid;
   logic [`LSU_XLEN-1:0]      r_ex2_word;
   logic [1:0]                r_ex2_off;
   mem_op_t                   r_ex2_op;
   logic [`LSU_PREG_W-1:0]    r_ex2_rd;
   logic [`LSU_CMT_ID_W-1:0]  r_ex2_cmt_id;
   logic [`LSU_DISP_SIZE-1:0] r_ex2_grp_id;
   logic [7:0]                w_ex2_byte;
   logic [15:0]               w_ex2_half;
   logic [`LSU_XLEN-1:0]      w_ex2_data;

   logic                      r_ex3_valid;
   logic [`LSU_PREG_W-1:0]    r_ex3_rd;
   logic [`LSU_XLEN-1:0]      r_ex3_data;

   always_ff @(posedge i_clk) begin
      if (i_mem_wr_valid) begin
         r_mem[i_mem_wr_addr[`LSU_ADDR_W-1:2]] <= i_mem_wr_data;
      end
   end

   // Address generation and scratchpad read in ex1.
   assign o_ex1_rs1  = r_ex1_issue.inst.rs1;
   assign w_ex1_addr = i_ex1_rs1_data + {{(`LSU_XLEN-12){r_ex1_issue.inst.imm[11]}},
                                         r_ex1_issue.inst.imm};
   assign w_ex1_word = r_mem[w_ex1_addr[`LSU_ADDR_W-1:2]];

   assign o_ex1_early_wr.valid = r_ex1_valid;
   assign o_ex1_early_wr.rd    = r_ex1_issue.inst.rd;   // Lets a dependent issue two later.

   // Alignment and extension in ex2.
   assign w_ex2_byte = r_ex2_word[{r_ex2_off, 3'b000} +: 8];
   assign w_ex2_half = r_ex2_word[{r_ex2_off[1], 4'b0000} +: 16];

   always_comb begin
      case (r_ex2_op)
         OP_LB:   w_ex2_data = {{(`LSU_XLEN-8){w_ex2_byte[7]}}, w_ex2_byte};
         OP_LH:   w_ex2_data = {{(`LSU_XLEN-16){w_ex2_half[15]}}, w_ex2_half};
         OP_LBU:  w_ex2_data = {{(`LSU_XLEN-8){1'b0}}, w_ex2_byte};
         OP_LHU:  w_ex2_data = {{(`LSU_XLEN-16){1'b0}}, w_ex2_half};
         default: w_ex2_data = r_ex2_word;   // OP_LW.
      endcase
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         r_ex1_valid <= 1'b0;
         r_ex2_valid <= 1'b0;
         r_ex3_valid <= 1'b0;
      end else begin
         r_ex1_valid <= i_rv0_valid;
         r_ex2_valid <= r_ex1_valid;
         r_ex3_valid <= r_ex2_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      r_ex1_issue  <= i_rv0_issue;
      r_ex2_word   <= w_ex1_word;
      r_ex2_off    <= w_ex1_addr[1:0];
      r_ex2_op     <= r_ex1_issue.inst.opcode;
      r_ex2_rd     <= r_ex1_issue.inst.rd;
      r_ex2_cmt_id <= r_ex1_issue.cmt_id;
      r_ex2_grp_id <= r_ex1_issue.grp_id;
      r_ex3_rd     <= r_ex2_rd;
      r_ex3_data   <= w_ex2_data;
      o_ex3_cmt_id <= r_ex2_cmt_id;
      o_ex3_grp_id <= r_ex2_grp_id;
   end

   assign o_ex3_phy_wr.valid = r_ex3_valid;
   assign o_ex3_phy_wr.rd    = r_ex3_rd;
   assign o_ex3_phy_wr.data  = r_ex3_data;

endmodule

`default_nettype wire

// ==== hw/lsu_scheduler.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_scheduler (
   input  logic                      i_clk,
   input  logic                      i_arst_n,

   lsu_disp_if.slave                 disp,
   input  logic [1:0]                i_pick_valid,
   input  lsu_core_pkg::disp_t       i_pick_inst[2],
   input  logic [`LSU_DISP_SIZE-1:0] i_pick_grp_id[2],

   input  lsu_core_pkg::early_wr_t   i_early_wr[2],

   output logic                      o_issue_valid,
   output lsu_core_pkg::issue_t      o_issue
);

   import lsu_core_pkg::*;
   import lsu_mem_pkg::*;

   issue_t       r_entry[`LSU_SCHED_ENTRIES];
   sched_state_t r_state[`LSU_SCHED_ENTRIES];

   logic [`LSU_SCHED_ENTRIES-1:0] w_wake;
   logic [`LSU_SCHED_ENTRIES-1:0] w_free_oh[2];
   logic [`LSU_SCHED_ENTRIES-1:0] w_iss_oh;
   logic [1:0]                    w_pick_ready;
   logic [1:0]                    w_pick_we;

   // Wakeup against both early writes, for waiting entries and incoming picks.
   always_comb begin
      for (int i = 0; i < `LSU_SCHED_ENTRIES; i++) begin
         w_wake[i] = 1'b0;
         for (int k = 0; k < 2; k++) begin
            if (i_early_wr[k].valid && i_early_wr[k].rd == r_entry[i].inst.rs1) begin
               w_wake[i] = 1'b1;
            end
         end
      end
      for (int p = 0; p < 2; p++) begin
         w_pick_ready[p] = i_pick_inst[p].rs1_ready;
         for (int k = 0; k < 2; k++) begin
            if (i_early_wr[k].valid && i_early_wr[k].rd == i_pick_inst[p].rs1) begin
               w_pick_ready[p] = 1'b1;
            end
         end
      end
   end

   assign w_pick_we = i_pick_valid & {2{disp.valid}};

   // First and second free entries by index.
   always_comb begin
      logic [1:0] seen;
      seen         = 2'b00;
      w_free_oh[0] = '0;
      w_free_oh[1] = '0;
      for (int i = 0; i < `LSU_SCHED_ENTRIES; i++) begin
         if (r_state[i] == ENTRY_EMPTY) begin
            if (!seen[0]) begin
               w_free_oh[0][i] = 1'b1;
               seen[0]         = 1'b1;
            end else if (!seen[1]) begin
               w_free_oh[1][i] = 1'b1;
               seen[1]         = 1'b1;
            end
         end
      end
   end

   // Oldest index wins.
   always_comb begin
      o_issue_valid = 1'b0;
      o_issue       = '0;
      w_iss_oh      = '0;
      for (int i = 0; i < `LSU_SCHED_ENTRIES; i++) begin
         if (r_state[i] == ENTRY_READY && !o_issue_valid) begin
            o_issue_valid = 1'b1;
            o_issue       = r_entry[i];
            w_iss_oh[i]   = 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `LSU_SCHED_ENTRIES; i++) begin
            r_state[i] <= ENTRY_EMPTY;
         end
      end else begin
         for (int i = 0; i < `LSU_SCHED_ENTRIES; i++) begin
            if (w_iss_oh[i]) begin
               r_state[i] <= ENTRY_EMPTY;     // Freed at end of rv0.
            end else if (r_state[i] == ENTRY_WAIT && w_wake[i]) begin
               r_state[i] <= ENTRY_READY;
            end else if (w_pick_we[0] && w_free_oh[0][i]) begin
               r_state[i] <= w_pick_ready[0] ? ENTRY_READY : ENTRY_WAIT;
            end else if (w_pick_we[1] && w_free_oh[1][i]) begin
               r_state[i] <= w_pick_ready[1] ? ENTRY_READY : ENTRY_WAIT;
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      for (int i = 0; i < `LSU_SCHED_ENTRIES; i++) begin
         for (int p = 0; p < 2; p++) begin
            if (w_pick_we[p] && w_free_oh[p][i]) begin
               r_entry[i].inst   <= i_pick_inst[p];
               r_entry[i].cmt_id <= disp.cmt_id;
               r_entry[i].grp_id <= i_pick_grp_id[p];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_top (
   input  logic                      i_clk,
   input  logic                      i_arst_n,

   input  logic                      i_disp_valid,
   input  logic [`LSU_CMT_ID_W-1:0]  i_disp_cmt_id,
   input  logic [`LSU_DISP_SIZE-1:0] i_disp_slot_valid,
   input  lsu_core_pkg::disp_t       i_disp_inst[`LSU_DISP_SIZE],

   input  logic                      i_ext_wr_valid,
   input  logic [`LSU_PREG_W-1:0]    i_ext_wr_rd,
   input  logic [`LSU_XLEN-1:0]      i_ext_wr_data,

   input  logic                      i_mem_wr_valid,
   input  logic [`LSU_ADDR_W-1:0]    i_mem_wr_addr,
   input  logic [`LSU_XLEN-1:0]      i_mem_wr_data,

   output logic                      o_wb_valid,
   output logic [`LSU_PREG_W-1:0]    o_wb_rd,
   output logic [`LSU_XLEN-1:0]      o_wb_data,
   output logic [`LSU_CMT_ID_W-1:0]  o_done_cmt_id,
   output logic [`LSU_DISP_SIZE-1:0] o_done_grp_id
);

   import lsu_core_pkg::*;

   lsu_disp_if u_disp_if ();

   logic [`LSU_DISP_SIZE-1:0] w_pick_valids;
   logic [1:0]                w_picked_valid;
   disp_t                     w_picked_inst[2];
   logic [`LSU_DISP_SIZE-1:0] w_picked_grp_id[2];

   logic                   w_rv0_valid;
   issue_t                 w_rv0_issue;
   logic [`LSU_PREG_W-1:0] w_ex1_rs1;
   logic [`LSU_XLEN-1:0]   w_ex1_rs1_data;
   early_wr_t              w_ex1_early_wr;
   early_wr_t              w_early_wr[2];
   phy_wr_t                w_ex3_phy_wr;
   phy_wr_t                w_phy_wr[2];

   assign u_disp_if.valid      = i_disp_valid;
   assign u_disp_if.cmt_id     = i_disp_cmt_id;
   assign u_disp_if.slot_valid = i_disp_slot_valid;
   assign u_disp_if.inst       = i_disp_inst;

   assign w_pick_valids = u_disp_if.slot_valid & {`LSU_DISP_SIZE{u_disp_if.valid}};

   generate
      for (genvar p = 0; p < 2; p++) begin : g_pick
         bit_pick_1_index #(
            .NUM (p)
         ) u_bit_pick_1_index (
            .i_valids     (w_pick_valids),
            .i_data       (u_disp_if.inst),
            .o_valid      (w_picked_valid[p]),
            .o_data       (w_picked_inst[p]),
            .o_picked_pos (w_picked_grp_id[p])
         );
      end
   endgenerate

   // Element 0 is the external port, element 1 the pipe.
   assign w_early_wr[0].valid = i_ext_wr_valid;
   assign w_early_wr[0].rd    = i_ext_wr_rd;
   assign w_early_wr[1]       = w_ex1_early_wr;

   assign w_phy_wr[0].valid = i_ext_wr_valid;
   assign w_phy_wr[0].rd    = i_ext_wr_rd;
   assign w_phy_wr[0].data  = i_ext_wr_data;
   assign w_phy_wr[1]       = w_ex3_phy_wr;

   lsu_scheduler u_lsu_scheduler (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .disp          (u_disp_if.slave),
      .i_pick_valid  (w_picked_valid),
      .i_pick_inst   (w_picked_inst),
      .i_pick_grp_id (w_picked_grp_id),
      .i_early_wr    (w_early_wr),
      .o_issue_valid (w_rv0_valid),
      .o_issue       (w_rv0_issue)
   );

   lsu_pipe u_lsu_pipe (
      .i_clk          (i_clk),
      .i_arst_n       (i_arst_n),
      .i_rv0_valid    (w_rv0_valid),
      .i_rv0_issue    (w_rv0_issue),
      .o_ex1_rs1      (w_ex1_rs1),
      .i_ex1_rs1_data (w_ex1_rs1_data),
      .o_ex1_early_wr (w_ex1_early_wr),
      .i_mem_wr_valid (i_mem_wr_valid),
      .i_mem_wr_addr  (i_mem_wr_addr),
      .i_mem_wr_data  (i_mem_wr_data),
      .o_ex3_phy_wr   (w_ex3_phy_wr),
      .o_ex3_cmt_id   (o_done_cmt_id),
      .o_ex3_grp_id   (o_done_grp_id)
   );

   lsu_phy_regfile u_lsu_phy_regfile (
      .i_clk     (i_clk),
      .i_arst_n  (i_arst_n),
      .i_wr      (w_phy_wr),
      .i_rd_idx  (w_ex1_rs1),
      .o_rd_data (w_ex1_rs1_data)
   );

   assign o_wb_valid = w_ex3_phy_wr.valid;
   assign o_wb_rd    = w_ex3_phy_wr.rd;
   assign o_wb_data  = w_ex3_phy_wr.data;

endmodule

`default_nettype wire

// ==== tb/tb_lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_top;

   import lsu_core_pkg::*;
   import lsu_mem_pkg::*;

   localparam int NROWS   = 14;
   localparam int TIMEOUT = NROWS * 12 + 200;

   logic                      i_clk;
   logic                      i_arst_n;
   logic                      i_disp_valid;
   logic [`LSU_CMT_ID_W-1:0]  i_disp_cmt_id;
   logic [`LSU_DISP_SIZE-1:0] i_disp_slot_valid;
   disp_t                     i_disp_inst[`LSU_DISP_SIZE];
   logic                      i_ext_wr_valid;
   logic [`LSU_PREG_W-1:0]    i_ext_wr_rd;
   logic [`LSU_XLEN-1:0]      i_ext_wr_data;
   logic                      i_mem_wr_valid;
   logic [`LSU_ADDR_W-1:0]    i_mem_wr_addr;
   logic [`LSU_XLEN-1:0]      i_mem_wr_data;
   logic                      o_wb_valid;
   logic [`LSU_PREG_W-1:0]    o_wb_rd;
   logic [`LSU_XLEN-1:0]      o_wb_data;
   logic [`LSU_CMT_ID_W-1:0]  o_done_cmt_id;
   logic [`LSU_DISP_SIZE-1:0] o_done_grp_id;

   // Stimulus table with one dispatch group per row.
   logic [`LSU_CMT_ID_W-1:0]  row_cmt[NROWS];
   logic [`LSU_DISP_SIZE-1:0] row_sv[NROWS];
   disp_t                     row_inst[NROWS][`LSU_DISP_SIZE];
   logic                      row_ext_v[NROWS];
   logic [`LSU_PREG_W-1:0]    row_ext_rd[NROWS];
   logic [`LSU_XLEN-1:0]      row_ext_data[NROWS];
   int                        nrows = 0;

   // Reference model and expected writebacks.
   logic [`LSU_XLEN-1:0]      model_mem[`LSU_MEM_WORDS];
   logic [`LSU_XLEN-1:0]      model_reg[`LSU_PHY_REGS];
   logic [`LSU_XLEN-1:0]      exp_data[`LSU_PHY_REGS];
   logic [`LSU_CMT_ID_W-1:0]  exp_cmt[`LSU_PHY_REGS];
   logic [`LSU_DISP_SIZE-1:0] exp_grp[`LSU_PHY_REGS];
   bit                        exp_after_ext[`LSU_PHY_REGS];
   bit                        exp_pending[`LSU_PHY_REGS];
   bit                        wb_seen[`LSU_PHY_REGS];
   int                        pending_cnt = 0;

   int cyc       = 0;
   int disp_cyc  = 0;
   int ext_cyc   = 0;
   bit lat_armed = 1'b0;
   bit row_lat_check = 1'b0;
   bit dispatched    = 1'b0;
   int n_checks  = 0;
   int n_errors  = 0;

   lsu_top i_dut (
      .i_clk             (i_clk),
      .i_arst_n          (i_arst_n),
      .i_disp_valid      (i_disp_valid),
      .i_disp_cmt_id     (i_disp_cmt_id),
      .i_disp_slot_valid (i_disp_slot_valid),
      .i_disp_inst       (i_disp_inst),
      .i_ext_wr_valid    (i_ext_wr_valid),
      .i_ext_wr_rd       (i_ext_wr_rd),
      .i_ext_wr_data     (i_ext_wr_data),
      .i_mem_wr_valid    (i_mem_wr_valid),
      .i_mem_wr_addr     (i_mem_wr_addr),
      .i_mem_wr_data     (i_mem_wr_data),
      .o_wb_valid        (o_wb_valid),
      .o_wb_rd           (o_wb_rd),
      .o_wb_data         (o_wb_data),
      .o_done_cmt_id     (o_done_cmt_id),
      .o_done_grp_id     (o_done_grp_id)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      n_checks = n_checks + 1;
      if (actual !== expected) begin
         n_errors = n_errors + 1;
         $display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
      end
   endtask

   function automatic disp_t load_slot(input mem_op_t op, input int rd, input int rs1,
                                       input int rdy, input logic [11:0] imm);
      disp_t s;
      s.opcode    = op;
      s.rd        = 5'(rd);
      s.rs1       = 5'(rs1);
      s.rs1_ready = (rdy != 0);
      s.imm       = imm;
      return s;
   endfunction

   task automatic add_row(input logic [3:0] cmt, input logic [3:0] sv, input logic ext_v,
                          input logic [4:0] ext_rd, input logic [31:0] ext_data,
                          input disp_t s0, input disp_t s1, input disp_t s2, input disp_t s3);
      row_cmt[nrows]      = cmt;
      row_sv[nrows]       = sv;
      row_ext_v[nrows]    = ext_v;
      row_ext_rd[nrows]   = ext_rd;
      row_ext_data[nrows] = ext_data;
      row_inst[nrows][0]  = s0;
      row_inst[nrows][1]  = s1;
      row_inst[nrows][2]  = s2;
      row_inst[nrows][3]  = s3;
      nrows = nrows + 1;
   endtask

   // r31 and r30 are never written and serve as base zero.
   task automatic build_table();
      disp_t idle;
      idle = load_slot(OP_LW, 31, 31, 1, 12'h000);   // Must never execute.
      add_row(4'd1, 4'b0011, 1'b0, 5'd0, 32'h0, load_slot(OP_LB, 0, 31, 1, 12'h000),
              load_slot(OP_LB, 1, 31, 1, 12'h005), idle, idle);
      add_row(4'd2, 4'b1010, 1'b0, 5'd0, 32'h0, idle, load_slot(OP_LB, 2, 31, 1, 12'h00A),
              idle, load_slot(OP_LB, 3, 31, 1, 12'h0FF));
      add_row(4'd3, 4'b1110, 1'b0, 5'd0, 32'h0, idle, load_slot(OP_LH, 4, 31, 1, 12'h020),
              load_slot(OP_LH, 5, 31, 1, 12'h031), idle);
      add_row(4'd4, 4'b0101, 1'b0, 5'd0, 32'h0, load_slot(OP_LH, 6, 31, 1, 12'h042),
              idle, load_slot(OP_LH, 7, 31, 1, 12'hFFF), idle);
      add_row(4'd5, 4'b1111, 1'b0, 5'd0, 32'h0, load_slot(OP_LW, 8, 31, 1, 12'h080),
              load_slot(OP_LW, 9, 31, 1, 12'h0C1), idle, idle);
      add_row(4'd6, 4'b1001, 1'b0, 5'd0, 32'h0, load_slot(OP_LW, 10, 31, 1, 12'h012),
              idle, idle, load_slot(OP_LW, 11, 31, 1, 12'h0E7));
      add_row(4'd7, 4'b0011, 1'b0, 5'd0, 32'h0, load_slot(OP_LBU, 12, 31, 1, 12'h034),
              load_slot(OP_LBU, 13, 31, 1, 12'h0F5), idle, idle);
      add_row(4'd8, 4'b0110, 1'b0, 5'd0, 32'h0, idle, load_slot(OP_LBU, 14, 31, 1, 12'h06A),
              load_slot(OP_LBU, 15, 31, 1, 12'hFF7), idle);
      add_row(4'd9, 4'b1100, 1'b0, 5'd0, 32'h0, idle, idle,
              load_slot(OP_LHU, 16, 31, 1, 12'h0A0), load_slot(OP_LHU, 17, 31, 1, 12'h0B9));
      add_row(4'd10, 4'b0111, 1'b0, 5'd0, 32'h0, load_slot(OP_LHU, 18, 31, 1, 12'h0CE),
              load_slot(OP_LHU, 19, 31, 1, 12'h0DB), idle, idle);
      // Dependent chains inside one group.
      add_row(4'd11, 4'b0011, 1'b0, 5'd0, 32'h0, load_slot(OP_LW, 20, 31, 1, 12'h04C),
              load_slot(OP_LBU, 21, 20, 0, 12'h003), idle, idle);
      add_row(4'd12, 4'b0101, 1'b0, 5'd0, 32'h0, load_slot(OP_LHU, 22, 9, 1, 12'h010),
              idle, load_slot(OP_LH, 23, 22, 0, 12'hFFE), idle);
      // Loads woken by the external write port.
      add_row(4'd13, 4'b0011, 1'b1, 5'd28, 32'h0000_0040, load_slot(OP_LW, 24, 28, 0, 12'h004),
              load_slot(OP_LB, 25, 28, 0, 12'h011), idle, idle);
      add_row(4'd14, 4'b1010, 1'b1, 5'd29, 32'h1234_5678, idle,
              load_slot(OP_LBU, 26, 30, 1, 12'h0F0), idle, load_slot(OP_LW, 27, 29, 0, 12'h008));
   endtask

   function automatic logic [31:0] extend_load(input mem_op_t op, input logic [31:0] word,
                                               input logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = 8'(word >> (8 * off));
      h = off[1] ? word[31:16] : word[15:0];
      case (op)
         OP_LB:   return {{24{b[7]}}, b};
         OP_LH:   return {{16{h[15]}}, h};
         OP_LBU:  return {24'h0, b};
         OP_LHU:  return {16'h0, h};
         default: return word;   // Word loads ignore the low address bits.
      endcase
   endfunction

   // Only the first two valid slots execute in slot order.
   task automatic predict_row(input int r);
      disp_t       d;
      logic [31:0] addr;
      logic [31:0] val;
      int          npick;
      npick         = 0;
      row_lat_check = 1'b0;
      ext_cyc       = 32'h7fff_ffff;
      if (row_ext_v[r]) begin
         model_reg[row_ext_rd[r]] = row_ext_data[r];
      end
      for (int s = 0; s < `LSU_DISP_SIZE; s++) begin
         if (row_sv[r][s] && npick < 2) begin
            d    = row_inst[r][s];
            addr = model_reg[d.rs1] + {{20{d.imm[11]}}, d.imm};
            val  = extend_load(d.opcode, model_mem[addr[7:2]], addr[1:0]);
            model_reg[d.rd]     = val;
            exp_data[d.rd]      = val;
            exp_cmt[d.rd]       = row_cmt[r];
            exp_grp[d.rd]       = 4'b0001 << s;
            exp_after_ext[d.rd] = row_ext_v[r] && (d.rs1 == row_ext_rd[r]);
            exp_pending[d.rd]   = 1'b1;
            pending_cnt         = pending_cnt + 1;
            if (d.rs1_ready) begin
               row_lat_check = 1'b1;
            end
            npick = npick + 1;
         end
      end
   endtask

   task automatic fill_scratchpad();
      for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
         @(posedge i_clk);
         model_mem[w]   = $urandom();
         i_mem_wr_valid <= 1'b1;
         i_mem_wr_addr  <= 8'(w * 4);
         i_mem_wr_data  <= model_mem[w];
      end
      @(posedge i_clk);
      i_mem_wr_valid <= 1'b0;
   endtask

   task automatic apply_row(input int r);
      predict_row(r);
      @(posedge i_clk);
      i_disp_valid      <= 1'b1;
      i_disp_cmt_id     <= row_cmt[r];
      i_disp_slot_valid <= row_sv[r];
      for (int s = 0; s < `LSU_DISP_SIZE; s++) begin
         i_disp_inst[s] <= row_inst[r][s];
      end
      disp_cyc   = cyc + 1;   // Cycle in which the strobe is high.
      lat_armed  = 1'b1;
      dispatched = 1'b1;
      @(posedge i_clk);
      i_disp_valid <= 1'b0;
      if (row_ext_v[r]) begin
         repeat (4) @(posedge i_clk);   // Later than a ready load would write back.
         i_ext_wr_valid <= 1'b1;
         i_ext_wr_rd    <= row_ext_rd[r];
         i_ext_wr_data  <= row_ext_data[r];
         ext_cyc = cyc + 1;
         @(posedge i_clk);
         i_ext_wr_valid <= 1'b0;
      end
      while (pending_cnt != 0) begin
         @(posedge i_clk);
      end
   endtask

   // Outputs change on the rising edge, so they are sampled on the falling one.
   always @(negedge i_clk) begin
      logic [4:0] rd;
      rd = o_wb_rd;
      if (i_arst_n && !dispatched) begin
         check_value("o_wb_valid", 32'(o_wb_valid), 32'd0);
      end else if (i_arst_n && o_wb_valid) begin
         if (!exp_pending[rd]) begin
            n_errors = n_errors + 1;
            if (wb_seen[rd]) begin
               $display("Duplicate writeback to r%0d at %0t", rd, $time);
            end else begin
               $display("Writeback to unexpected register r%0d at %0t", rd, $time);
            end
         end else begin
            check_value("o_wb_data", o_wb_data, exp_data[rd]);
            check_value("o_done_cmt_id", 32'(o_done_cmt_id), 32'(exp_cmt[rd]));
            check_value("o_done_grp_id", 32'(o_done_grp_id), 32'(exp_grp[rd]));
            if (exp_after_ext[rd] && cyc <= ext_cyc) begin
               n_errors = n_errors + 1;
               $display("Load to r%0d wrote back before its external write at %0t",
                        rd, $time);
            end
            if (lat_armed && row_lat_check) begin
               check_value("wb_latency", 32'(cyc - disp_cyc), 32'd4);
            end
            lat_armed       = 1'b0;
            exp_pending[rd] = 1'b0;
            wb_seen[rd]     = 1'b1;
            pending_cnt     = pending_cnt - 1;
         end
      end
   end

   always @(posedge i_clk) begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT) begin
         for (int i = 0; i < `LSU_PHY_REGS; i++) begin
            if (exp_pending[i]) begin
               $display("Load to r%0d was never written back", i);
            end
         end
         n_errors = n_errors + 1;
         $display("Run stopped after %0d cycles without finishing", cyc);
         $display("Checks: %0d, errors: %0d", n_checks, n_errors);
         $display("TEST FAIL");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'ha848));
      i_arst_n          = 1'b0;
      i_disp_valid      = 1'b0;
      i_disp_cmt_id     = '0;
      i_disp_slot_valid = '0;
      i_ext_wr_valid    = 1'b0;
      i_ext_wr_rd       = '0;
      i_ext_wr_data     = '0;
      i_mem_wr_valid    = 1'b0;
      i_mem_wr_addr     = '0;
      i_mem_wr_data     = '0;
      for (int s = 0; s < `LSU_DISP_SIZE; s++) begin
         i_disp_inst[s] = '0;
      end
      for (int i = 0; i < `LSU_PHY_REGS; i++) begin
         model_reg[i]   = '0;   // Register file resets to zero.
         exp_pending[i] = 1'b0;
         wb_seen[i]     = 1'b0;
      end
      build_table();
      repeat (4) @(posedge i_clk);
      i_arst_n <= 1'b1;
      fill_scratchpad();
      for (int r = 0; r < NROWS; r++) begin
         apply_row(r);
      end
      repeat (10) @(posedge i_clk);   // Catch stray writebacks.
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
